// File: verilog.f
+incdir+source
source/physRegPkg.sv
source/pipeCtrlPkg.sv
source/stageIf.sv
source/operandFetch.sv
source/bypassNetwork.sv
source/issueOutputStage.sv
source/readyScoreboard.sv
source/regRead.sv
verif/regRead_tb.sv

// File: Makefile
SOURCES := $(filter-out +%,$(shell cat verilog.f))

.PHONY: run clean

run: obj_dir/VregRead_tb
	./obj_dir/VregRead_tb | tee sim.log
	grep -q "^Test passed$$" sim.log

obj_dir/VregRead_tb: verilog.f $(SOURCES) source/regRead_config.svh
	verilator --binary --top-module regRead_tb -f verilog.f

clean:
	rm -rf obj_dir sim.log

// File: verif/regRead_tb.sv
`include "regRead_config.svh"

module regRead_tb
  import physRegPkg::*;
  import pipeCtrlPkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int L = `RR_ISSUE_LANES;
  localparam int W = `RR_WB_LANES;

  logic clk, arstN_i, recover_i, mispredict_i, exception_i;
  logic [L-1:0] issueValid_i;
  issueTagArr_t issueSrc1_i, issueSrc2_i;
  ckptMask_t [L-1:0] issueMask_i;
  payload_t [L-1:0] issuePayload_i;
  logic [W-1:0] wbValid_i;
  wbTagArr_t wbDest_i;
  wbDataArr_t wbData_i;
  ckptId_t mispredictCkpt_i;
  logic [`RR_UNMAP_LANES-1:0] unmapValid_i;
  physTag_t [`RR_UNMAP_LANES-1:0] unmapTag_i;
  logic [`RR_WAKE_LANES-1:0] wakeValid_i;
  physTag_t [`RR_WAKE_LANES-1:0] wakeTag_i;
  logic [L-1:0] outValid_o;
  issueDataArr_t outOpnd1_o, outOpnd2_o;
  payload_t [L-1:0] outPayload_o;
  readyVec_t phyRegRdy_o;

  typedef struct packed {
    logic [L-1:0] issued;
    logic [L-1:0] valid;
    logic [L-1:0] known1;
    logic [L-1:0] known2;
    issueDataArr_t op1;
    issueDataArr_t op2;
    payload_t [L-1:0] pay;
  } expect_t;

  // shadow state of the model.
  regData_t shadowFile [`RR_PHYS_REGS];
  bit written [`RR_PHYS_REGS];
  readyVec_t shadowReady;
  expect_t expQ[$];
  int checks, errors;
  bit waitOk;

  regRead DUT (.*);

  always #2 clk = ~clk;

  function automatic readyVec_t resetReady();
    readyVec_t m;
    m = '0;
    for (int i = 0; i < `RR_ARCH_REGS; i++) m[i] = 1'b1;
    return m;
  endfunction

  // same-cycle writeback beats the file.
  function automatic bit lookup(input physTag_t tag, output regData_t val);
    bit known;
    known = written[tag];
    val = shadowFile[tag];
    for (int w = 0; w < W; w++) begin
      if (wbValid_i[w] && wbDest_i[w] == tag) begin
        known = 1'b1;
        val = wbData_i[w];
      end
    end
    return known;
  endfunction

  task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic clearInputs();
    {issueValid_i, issueSrc1_i, issueSrc2_i, issueMask_i, issuePayload_i} = '0;
    {wbValid_i, wbDest_i, wbData_i, recover_i, mispredict_i, mispredictCkpt_i} = '0;
    {unmapValid_i, unmapTag_i, wakeValid_i, wakeTag_i, exception_i} = '0;
  endtask

  task automatic driveRandom(input bit wbOn, input bit recOn, input bit fwdOn,
                             input bit squashOn, input bit sbOn);
    int base;
    base = $urandom_range(`RR_PHYS_REGS - 1);
    // consecutive dests never collide.
    for (int w = 0; w < W; w++) begin
      wbValid_i[w] = wbOn && ($urandom_range(3) != 0);
      wbDest_i[w] = physTag_t'(base + w);
      wbData_i[w] = regData_t'($urandom());
    end
    recover_i = recOn && ($urandom_range(1) != 0);
    for (int l = 0; l < L; l++) begin
      issueValid_i[l] = ($urandom_range(3) != 0);
      issueSrc1_i[l] = physTag_t'($urandom_range(`RR_PHYS_REGS - 1));
      issueSrc2_i[l] = physTag_t'($urandom_range(`RR_PHYS_REGS - 1));
      if (fwdOn) issueSrc1_i[l] = wbDest_i[l % W];
      if (fwdOn && $urandom_range(1) != 0) issueSrc2_i[l] = wbDest_i[(l + 1) % W];
      issueMask_i[l] = ckptMask_t'($urandom());
      issuePayload_i[l] = payload_t'($urandom());
    end
    mispredict_i = squashOn && ($urandom_range(1) != 0);
    mispredictCkpt_i = ckptId_t'($urandom());
    for (int u = 0; u < `RR_UNMAP_LANES; u++) begin
      unmapValid_i[u] = sbOn && ($urandom_range(1) != 0);
      unmapTag_i[u] = physTag_t'($urandom_range(`RR_PHYS_REGS - 1));
    end
    for (int k = 0; k < `RR_WAKE_LANES; k++) begin
      wakeValid_i[k] = sbOn && ($urandom_range(1) != 0);
      wakeTag_i[k] = physTag_t'($urandom_range(`RR_PHYS_REGS - 1));
      if (k < `RR_UNMAP_LANES && $urandom_range(3) == 0) wakeTag_i[k] = unmapTag_i[k];
    end
    exception_i = 1'b0;
  endtask

  // ========================================
  // one clock of model and checks.
  // ========================================
  task automatic stepCycle();
    expect_t e;
    regData_t v;
    e = '0;
    for (int l = 0; l < L; l++) begin
      e.issued[l] = issueValid_i[l];
      e.valid[l] = issueValid_i[l] && !(mispredict_i && issueMask_i[l][mispredictCkpt_i]);
      e.pay[l] = issuePayload_i[l];
      e.known1[l] = lookup(issueSrc1_i[l], v);
      e.op1[l] = v;
      e.known2[l] = lookup(issueSrc2_i[l], v);
      e.op2[l] = v;
    end
    expQ.push_back(e);
    for (int w = 0; w < W; w++) begin
      if (wbValid_i[w] && !recover_i) begin
        shadowFile[wbDest_i[w]] = wbData_i[w];
        written[wbDest_i[w]] = 1'b1;
      end
    end
    if (exception_i) begin
      shadowReady = resetReady();
    end else begin
      for (int u = 0; u < `RR_UNMAP_LANES; u++)
        if (unmapValid_i[u]) shadowReady[unmapTag_i[u]] = 1'b0;
      for (int k = 0; k < `RR_WAKE_LANES; k++)
        if (wakeValid_i[k]) shadowReady[wakeTag_i[k]] = 1'b1;
    end
    @(posedge clk);
    #1;
    e = expQ.pop_front();
    for (int l = 0; l < L; l++) begin
      checkEq($sformatf("lane %0d valid", l), 32'(outValid_o[l]), 32'(e.valid[l]));
      if (e.issued[l]) begin
        checkEq($sformatf("lane %0d payload", l), 32'(outPayload_o[l]), 32'(e.pay[l]));
        if (e.known1[l]) checkEq($sformatf("lane %0d opnd1", l), outOpnd1_o[l], e.op1[l]);
        if (e.known2[l]) checkEq($sformatf("lane %0d opnd2", l), outOpnd2_o[l], e.op2[l]);
      end
    end
    checkEq("ready vector", 32'(phyRegRdy_o), 32'(shadowReady));
  endtask

  task automatic runRandom(input int cycles, input bit wbOn, input bit recOn,
                           input bit fwdOn, input bit squashOn, input bit sbOn);
    repeat (cycles) begin
      driveRandom(wbOn, recOn, fwdOn, squashOn, sbOn);
      stepCycle();
    end
  endtask

  task automatic reportTest(input int num, input string name, input int errBefore);
    $display("test %0d (%s) done, %0d errors", num, name, errors - errBefore);
  endtask

  task automatic waitValidIdle(input int limit, output bit ok);
    int n;
    n = 0;
    while (outValid_o !== '0 && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    ok = (outValid_o === '0);
  endtask

  task automatic runAllTests();
    int errBefore;
    int base;
    errBefore = errors;
    checkEq("ready after reset", 32'(phyRegRdy_o), 32'(resetReady()));
    runRandom(6, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    clearInputs();
    exception_i = 1'b1;
    stepCycle();
    checkEq("ready after exception", 32'(phyRegRdy_o), 32'(resetReady()));
    reportTest(1, "ready pattern", errBefore);

    errBefore = errors;
    for (int t = 0; t < `RR_PHYS_REGS; t += W) begin
      clearInputs();
      for (int w = 0; w < W; w++) begin
        wbValid_i[w] = 1'b1;
        wbDest_i[w] = physTag_t'(t + w);
        wbData_i[w] = regData_t'($urandom());
      end
      stepCycle();
    end
    runRandom(40, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    reportTest(2, "file reads", errBefore);

    errBefore = errors;
    runRandom(40, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
    reportTest(3, "forwarding", errBefore);

    errBefore = errors;
    for (int r = 0; r < 10; r++) begin
      base = $urandom_range(`RR_PHYS_REGS - 1);
      clearInputs();
      recover_i = 1'b1;
      for (int w = 0; w < W; w++) begin
        wbValid_i[w] = 1'b1;
        wbDest_i[w] = physTag_t'(base + w);
        wbData_i[w] = regData_t'($urandom());
      end
      stepCycle();
      // read back the tags that were not written.
      clearInputs();
      for (int l = 0; l < L; l++) begin
        issueValid_i[l] = 1'b1;
        issueSrc1_i[l] = physTag_t'(base + l % W);
        issueSrc2_i[l] = physTag_t'(base + (l + 1) % W);
        issuePayload_i[l] = payload_t'($urandom());
      end
      stepCycle();
    end
    reportTest(4, "blocked writes", errBefore);

    errBefore = errors;
    runRandom(40, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
    reportTest(5, "squash", errBefore);

    errBefore = errors;
    runRandom(60, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    reportTest(6, "scoreboard", errBefore);
  endtask

  // ========================================
  // main sequence.
  // ========================================
  initial begin
    void'($urandom(32'ha617));
    clk = 1'b0;
    arstN_i = 1'b0;
    clearInputs();
    shadowReady = resetReady();
    repeat (8) @(posedge clk);
    #1;
    arstN_i = 1'b1;
    waitValidIdle(8, waitOk);
    if (!waitOk) begin
      $display("timed out waiting for the valid outputs to clear after reset");
    end else begin
      runAllTests();
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (waitOk && errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: source/regRead.sv
`include "regRead_config.svh"

module regRead
  import physRegPkg::*;
  import pipeCtrlPkg::*;
(
  input  logic                            clk,
  input  logic                            arstN_i,

  // ========================================
  // issue lanes.
  // ========================================
  input  logic [`RR_ISSUE_LANES-1:0]      issueValid_i,
  input  issueTagArr_t                    issueSrc1_i,
  input  issueTagArr_t                    issueSrc2_i,
  input  ckptMask_t [`RR_ISSUE_LANES-1:0] issueMask_i,
  input  payload_t [`RR_ISSUE_LANES-1:0]  issuePayload_i,

  // ========================================
  // writeback and recovery.
  // ========================================
  input  logic [`RR_WB_LANES-1:0]         wbValid_i,
  input  wbTagArr_t                       wbDest_i,
  input  wbDataArr_t                      wbData_i,
  input  logic                            recover_i,
  input  logic                            mispredict_i,
  input  ckptId_t                         mispredictCkpt_i,

  // scoreboard traffic.
  input  logic [`RR_UNMAP_LANES-1:0]      unmapValid_i,
  input  physTag_t [`RR_UNMAP_LANES-1:0]  unmapTag_i,
  input  logic [`RR_WAKE_LANES-1:0]       wakeValid_i,
  input  physTag_t [`RR_WAKE_LANES-1:0]   wakeTag_i,
  input  logic                            exception_i,

  output logic [`RR_ISSUE_LANES-1:0]      outValid_o,
  output issueDataArr_t                   outOpnd1_o,
  output issueDataArr_t                   outOpnd2_o,
  output payload_t [`RR_ISSUE_LANES-1:0]  outPayload_o,
  output readyVec_t                       phyRegRdy_o
);

  readIf rdBus ();
  execIf exBus ();

  operandFetch uFetch (
    .clk            (clk),
    .issueValid_i   (issueValid_i),
    .issueSrc1_i    (issueSrc1_i),
    .issueSrc2_i    (issueSrc2_i),
    .issueMask_i    (issueMask_i),
    .issuePayload_i (issuePayload_i),
    .wbValid_i      (wbValid_i),
    .wbDest_i       (wbDest_i),
    .wbData_i       (wbData_i),
    .recover_i      (recover_i),
    .rd             (rdBus)
  );

  // forwarding stays on during recovery.
  bypassNetwork uBypass (
    .rd        (rdBus),
    .wbValid_i (wbValid_i),
    .wbDest_i  (wbDest_i),
    .wbData_i  (wbData_i),
    .ex        (exBus)
  );

  issueOutputStage uOut (
    .clk              (clk),
    .arstN_i          (arstN_i),
    .ex               (exBus),
    .mispredict_i     (mispredict_i),
    .mispredictCkpt_i (mispredictCkpt_i),
    .outValid_o       (outValid_o),
    .outOpnd1_o       (outOpnd1_o),
    .outOpnd2_o       (outOpnd2_o),
    .outPayload_o     (outPayload_o)
  );

  readyScoreboard uReady (
    .clk          (clk),
    .arstN_i      (arstN_i),
    .unmapValid_i (unmapValid_i),
    .unmapTag_i   (unmapTag_i),
    .wakeValid_i  (wakeValid_i),
    .wakeTag_i    (wakeTag_i),
    .exception_i  (exception_i),
    .phyRegRdy_o  (phyRegRdy_o)
  );

endmodule

// File: source/readyScoreboard.sv
`include "regRead_config.svh"

module readyScoreboard
  import physRegPkg::*;
(
  input  logic                           clk,
  input  logic                           arstN_i,

  input  logic [`RR_UNMAP_LANES-1:0]     unmapValid_i,
  input  physTag_t [`RR_UNMAP_LANES-1:0] unmapTag_i,
  input  logic [`RR_WAKE_LANES-1:0]      wakeValid_i,
  input  physTag_t [`RR_WAKE_LANES-1:0]  wakeTag_i,
  input  logic                           exception_i,

  output readyVec_t                      phyRegRdy_o
);

  readyVec_t readyNext;

  // architectural registers hold committed values.
  function automatic readyVec_t archPattern();
    readyVec_t pattern;
    pattern = '0;
    for (int i = 0; i < `RR_ARCH_REGS; i++) begin
      pattern[i] = 1'b1;
    end
    return pattern;
  endfunction

  // clear first, so a wakeup on the same tag wins.
  always_comb begin
    readyNext = phyRegRdy_o;
    for (int u = 0; u < `RR_UNMAP_LANES; u++) begin
      if (unmapValid_i[u]) readyNext[unmapTag_i[u]] = 1'b0;
    end
    for (int k = 0; k < `RR_WAKE_LANES; k++) begin
      if (wakeValid_i[k]) readyNext[wakeTag_i[k]] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      phyRegRdy_o <= archPattern();
    end else if (exception_i) begin
      phyRegRdy_o <= archPattern();
    end else begin
      phyRegRdy_o <= readyNext;
    end
  end

endmodule

// File: source/issueOutputStage.sv
`include "regRead_config.svh"

module issueOutputStage
  import physRegPkg::*;
  import pipeCtrlPkg::*;
(
  input  logic                           clk,
  input  logic                           arstN_i,

  execIf.out                             ex,

  input  logic                           mispredict_i,
  input  ckptId_t                        mispredictCkpt_i,

  output logic [`RR_ISSUE_LANES-1:0]     outValid_o,
  output issueDataArr_t                  outOpnd1_o,
  output issueDataArr_t                  outOpnd2_o,
  output payload_t [`RR_ISSUE_LANES-1:0] outPayload_o
);

  logic [`RR_ISSUE_LANES-1:0] liveValid;

  // kill lanes that depend on the mispredicted branch.
  always_comb begin
    for (int l = 0; l < `RR_ISSUE_LANES; l++) begin
      liveValid[l] = ex.valid[l] && !(mispredict_i && ex.mask[l][mispredictCkpt_i]);
    end
  end

  // ========================================
  // pipeline register.
  // ========================================
  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      outValid_o <= '0;
    end else begin
      outValid_o <= liveValid;
    end
  end

  always_ff @(posedge clk) begin
    outOpnd1_o   <= ex.opnd1;
    outOpnd2_o   <= ex.opnd2;
    outPayload_o <= ex.payload;
  end

endmodule

// File: source/bypassNetwork.sv
`include "regRead_config.svh"

module bypassNetwork
  import physRegPkg::*;
(
  readIf.bypass                   rd,

  input  logic [`RR_WB_LANES-1:0] wbValid_i,
  input  wbTagArr_t               wbDest_i,
  input  wbDataArr_t              wbData_i,

  execIf.network                  ex
);

  // last matching lane wins; no two lanes share a dest in one cycle.
  function automatic regData_t pickOperand(
    input physTag_t                 tag,
    input regData_t                 fileData,
    input logic [`RR_WB_LANES-1:0]  vld,
    input wbTagArr_t                dest,
    input wbDataArr_t               data
  );
    regData_t result;
    result = fileData;
    for (int w = 0; w < `RR_WB_LANES; w++) begin
      if (vld[w] && (dest[w] == tag)) begin
        result = data[w];
      end
    end
    return result;
  endfunction

  // ========================================
  // operand select per source.
  // ========================================
  always_comb begin
    for (int l = 0; l < `RR_ISSUE_LANES; l++) begin
      ex.opnd1[l] = pickOperand(rd.src1[l], rd.file1[l], wbValid_i, wbDest_i, wbData_i);
      ex.opnd2[l] = pickOperand(rd.src2[l], rd.file2[l], wbValid_i, wbDest_i, wbData_i);
    end
  end

  assign ex.valid   = rd.valid;
  assign ex.mask    = rd.mask;
  assign ex.payload = rd.payload;

endmodule

// File: source/operandFetch.sv
`include "regRead_config.svh"

module operandFetch
  import physRegPkg::*;
  import pipeCtrlPkg::*;
(
  input  logic                            clk,

  input  logic [`RR_ISSUE_LANES-1:0]      issueValid_i,
  input  issueTagArr_t                    issueSrc1_i,
  input  issueTagArr_t                    issueSrc2_i,
  input  ckptMask_t [`RR_ISSUE_LANES-1:0] issueMask_i,
  input  payload_t [`RR_ISSUE_LANES-1:0]  issuePayload_i,

  input  logic [`RR_WB_LANES-1:0]         wbValid_i,
  input  wbTagArr_t                       wbDest_i,
  input  wbDataArr_t                      wbData_i,
  input  logic                            recover_i,

  readIf.fetch                            rd
);

  regData_t regFile [`RR_PHYS_REGS];

  // ========================================
  // write ports.
  // ========================================
  // nothing lands in the file while recovering.
  always_ff @(posedge clk) begin
    for (int w = 0; w < `RR_WB_LANES; w++) begin
      if (wbValid_i[w] && !recover_i) begin
        regFile[wbDest_i[w]] <= wbData_i[w];
      end
    end
  end

  // ========================================
  // read ports, two per issue lane.
  // ========================================
  always_comb begin
    for (int l = 0; l < `RR_ISSUE_LANES; l++) begin
      rd.file1[l] = regFile[issueSrc1_i[l]];
      rd.file2[l] = regFile[issueSrc2_i[l]];
    end
  end

  // issue fields ride along with the read data.
  assign rd.valid   = issueValid_i;
  assign rd.src1    = issueSrc1_i;
  assign rd.src2    = issueSrc2_i;
  assign rd.mask    = issueMask_i;
  assign rd.payload = issuePayload_i;

endmodule

// File: source/stageIf.sv
`include "regRead_config.svh"

// ========================================
// fetched operands, one entry per issue lane.
// ========================================
interface readIf import physRegPkg::*, pipeCtrlPkg::*; ();
  logic [`RR_ISSUE_LANES-1:0]      valid;
  issueTagArr_t                    src1;
  issueTagArr_t                    src2;
  issueDataArr_t                   file1;
  issueDataArr_t                   file2;
  ckptMask_t [`RR_ISSUE_LANES-1:0] mask;
  payload_t [`RR_ISSUE_LANES-1:0]  payload;

  modport fetch (output valid, src1, src2, file1, file2, mask, payload);
  modport bypass (input valid, src1, src2, file1, file2, mask, payload);
endinterface

// ========================================
// resolved operands toward the output stage.
// ========================================
interface execIf import physRegPkg::*, pipeCtrlPkg::*; ();
  logic [`RR_ISSUE_LANES-1:0]      valid;
  issueDataArr_t                   opnd1;
  issueDataArr_t                   opnd2;
  ckptMask_t [`RR_ISSUE_LANES-1:0] mask;
  payload_t [`RR_ISSUE_LANES-1:0]  payload;

  modport network (output valid, opnd1, opnd2, mask, payload);
  modport out (input valid, opnd1, opnd2, mask, payload);
endinterface

// File: source/pipeCtrlPkg.sv
`include "regRead_config.svh"

package pipeCtrlPkg;

  // one bit per unresolved branch checkpoint.
  typedef logic [`RR_CKPTS-1:0]     ckptMask_t;
  typedef logic [`RR_CKPT_ID_W-1:0] ckptId_t;

  // opaque instruction tag, carried through untouched.
  typedef logic [`RR_PAYLOAD_W-1:0] payload_t;

endpackage

// File: source/physRegPkg.sv
`include "regRead_config.svh"

package physRegPkg;

  typedef logic [`RR_TAG_W-1:0]     physTag_t;
  typedef logic [`RR_DATA_W-1:0]    regData_t;
  typedef logic [`RR_PHYS_REGS-1:0] readyVec_t;

  // per-lane bundles.
  typedef physTag_t [`RR_ISSUE_LANES-1:0] issueTagArr_t;
  typedef regData_t [`RR_ISSUE_LANES-1:0] issueDataArr_t;
  typedef physTag_t [`RR_WB_LANES-1:0]    wbTagArr_t;
  typedef regData_t [`RR_WB_LANES-1:0]    wbDataArr_t;

endpackage

// File: source/regRead_config.svh
`ifndef REGREAD_CONFIG_SVH
`define REGREAD_CONFIG_SVH

// ========================================
// lane counts.
// ========================================
`define RR_ISSUE_LANES 2
`define RR_WB_LANES    2
`define RR_WAKE_LANES  2
`define RR_UNMAP_LANES 2

// ========================================
// register file and checkpoints.
// ========================================
`define RR_PHYS_REGS   32
`define RR_TAG_W       $clog2(`RR_PHYS_REGS)
// tags below this are mapped at reset.
`define RR_ARCH_REGS   8
`define RR_DATA_W      32

`define RR_CKPTS       4
`define RR_CKPT_ID_W   $clog2(`RR_CKPTS)
`define RR_PAYLOAD_W   16

`endif
